// ==== rtl/acc_cfg.svh ====
`ifndef ACC_CFG_SVH
`define ACC_CFG_SVH

// Queue counts
`define ACC_NUM_IN 2

// Field widths
`define ACC_DATA_W 32
`define ACC_ADDR_W 16
`define ACC_CNT_W 16
`define ACC_QID_W 8

// Queue id, base address and count side by side
`define ACC_CONF_W 40

`endif

// ==== rtl/acc_pkg.sv ====
`include "acc_cfg.svh"

package acc_pkg;

  // Kind of word on the configuration bus
  typedef enum logic [1:0] {
    conf_none   = 2'd0,
    conf_queue  = 2'd1,
    conf_status = 2'd2
  } conf_kind_t;

  typedef struct packed {
    logic [`ACC_QID_W-1:0]  qid;
    logic [`ACC_ADDR_W-1:0] base;
    logic [`ACC_CNT_W-1:0]  count;
  } queue_conf_t;

  typedef struct packed {
    logic [`ACC_CONF_W-`ACC_ADDR_W-1:0] rsvd;
    logic [`ACC_ADDR_W-1:0]             addr;
  } status_conf_t;

  // View picked by conf_valid
  typedef union packed {
    queue_conf_t  q;
    status_conf_t s;
  } conf_word_u;

endpackage

// ==== rtl/input_queue_ctrl.sv ====
`include "acc_cfg.svh"

module input_queue_ctrl
  import acc_pkg::*;
#(
  parameter logic [`ACC_QID_W-1:0] QUEUE_ID = '0
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  conf_kind_t             conf_valid,
  input  conf_word_u             conf,
  input  logic                   available_read,
  input  logic                   read_data_valid,
  input  logic [`ACC_QID_W-1:0]  read_queue_id,
  input  logic [`ACC_DATA_W-1:0] read_data,
  input  logic                   take,
  output logic                   request_read,
  output logic [`ACC_ADDR_W-1:0] request_addr,
  output logic                   word_ready,
  output logic [`ACC_DATA_W-1:0] word_data,
  output logic                   done
);

  logic                  started;
  logic                  pending;
  logic [`ACC_CNT_W-1:0] words_left;
  logic                  conf_hit;
  logic                  data_hit;

  assign conf_hit = (conf_valid == conf_queue) && (conf.q.qid == QUEUE_ID);
  assign data_hit = read_data_valid && (read_queue_id == QUEUE_ID);

  // One read in flight, and only into an empty buffer
  assign request_read = started && (words_left != '0) && !word_ready && !pending
                        && available_read;

  always_ff @(posedge clk) begin
    if (rst) begin
      started    <= 1'b0;
      pending    <= 1'b0;
      words_left <= '0;
      word_ready <= 1'b0;
      done       <= 1'b0;
    end else begin
      if (conf_hit) begin
        words_left <= conf.q.count;
      end
      if (start) begin
        started <= 1'b1;
      end
      if (request_read) begin
        pending    <= 1'b1;
        words_left <= words_left - 1'b1;
      end
      if (data_hit) begin
        pending    <= 1'b0;
        word_ready <= 1'b1;
      end
      if (take) begin
        word_ready <= 1'b0;
      end
      done <= started && (words_left == '0) && !pending && !word_ready;
    end
  end

  always_ff @(posedge clk) begin
    if (conf_hit) begin
      request_addr <= conf.q.base;
    end else if (request_read) begin
      request_addr <= request_addr + 1'b1;
    end
    if (data_hit) begin
      word_data <= read_data;
    end
  end

endmodule

// ==== rtl/output_queue_ctrl.sv ====
`include "acc_cfg.svh"

module output_queue_ctrl
  import acc_pkg::*;
#(
  parameter logic [`ACC_QID_W-1:0] QUEUE_ID = '0
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  conf_kind_t             conf_valid,
  input  conf_word_u             conf,
  input  logic                   push,
  input  logic [`ACC_DATA_W-1:0] push_data,
  input  logic                   available_write,
  input  logic                   write_ack,
  input  logic [`ACC_QID_W-1:0]  write_queue_id,
  output logic                   slot_free,
  output logic                   request_write,
  output logic [`ACC_ADDR_W-1:0] write_addr,
  output logic [`ACC_DATA_W-1:0] write_data,
  output logic                   done
);

  logic                  started;
  logic                  pending;
  logic                  full;
  logic [`ACC_CNT_W-1:0] total;
  logic [`ACC_CNT_W-1:0] acked;
  logic                  conf_hit;
  logic                  ack_hit;

  assign conf_hit = (conf_valid == conf_queue) && (conf.q.qid == QUEUE_ID);
  assign ack_hit  = write_ack && (write_queue_id == QUEUE_ID);

  assign slot_free = !full;

  // Buffer frees at the strobe, next write waits for the ack
  assign request_write = full && !pending && available_write;

  always_ff @(posedge clk) begin
    if (rst) begin
      started <= 1'b0;
      pending <= 1'b0;
      full    <= 1'b0;
      total   <= '0;
      acked   <= '0;
      done    <= 1'b0;
    end else begin
      if (conf_hit) begin
        total <= conf.q.count;
        acked <= '0;
      end
      if (start) begin
        started <= 1'b1;
      end
      if (push) begin
        full <= 1'b1;
      end
      if (request_write) begin
        full    <= 1'b0;
        pending <= 1'b1;
      end
      if (ack_hit) begin
        pending <= 1'b0;
        acked   <= acked + 1'b1;
      end
      done <= started && (acked == total);
    end
  end

  always_ff @(posedge clk) begin
    if (conf_hit) begin
      write_addr <= conf.q.base;
    end else if (request_write) begin
      write_addr <= write_addr + 1'b1;
    end
    if (push) begin
      write_data <= push_data;
    end
  end

endmodule

// ==== rtl/pair_sum_kernel.sv ====
`include "acc_cfg.svh"

module pair_sum_kernel (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   start,
  input  logic [`ACC_NUM_IN-1:0]                 word_ready,
  input  logic [`ACC_NUM_IN-1:0][`ACC_DATA_W-1:0] word_data,
  input  logic                                   slot_free,
  output logic                                   take,
  output logic                                   push,
  output logic [`ACC_DATA_W-1:0]                 push_data,
  output logic                                   kernel_busy
);

  logic pair_pending;

  // Pull a full set only when the output side can hold the result
  assign take = (&word_ready) && slot_free;
  assign push = take;

  // Wraps modulo 2^32
  always_comb begin
    push_data = '0;
    for (int i = 0; i < `ACC_NUM_IN; i++) begin
      push_data = push_data + word_data[i];
    end
  end

  // Busy while a word waits in an input buffer or a pair is on its way out
  always_ff @(posedge clk) begin
    if (rst) begin
      pair_pending <= 1'b0;
      kernel_busy  <= 1'b0;
    end else begin
      pair_pending <= take;
      if (start) begin
        kernel_busy <= 1'b1;
      end else begin
        kernel_busy <= (|word_ready) || pair_pending;
      end
    end
  end

endmodule

// ==== rtl/cycle_timer.sv ====
`include "acc_cfg.svh"

module cycle_timer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  logic                   freeze,
  output logic [`ACC_DATA_W-1:0] elapsed
);

  logic run;

  // Start arrives one edge after the host strobe, so counting begins at one
  always_ff @(posedge clk) begin
    if (rst) begin
      run     <= 1'b0;
      elapsed <= '0;
    end else if (start) begin
      run     <= 1'b1;
      elapsed <= `ACC_DATA_W'(1);
    end else if (freeze) begin
      run <= 1'b0;
    end else if (run) begin
      elapsed <= elapsed + 1'b1;
    end
  end

endmodule

// ==== rtl/status_ctrl.sv ====
`include "acc_cfg.svh"

module status_ctrl
  import acc_pkg::*;
#(
  parameter logic [`ACC_QID_W-1:0] QUEUE_ID = '0
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  conf_kind_t             conf_valid,
  input  conf_word_u             conf,
  input  logic [`ACC_NUM_IN:0]   queue_done,
  input  logic                   kernel_busy,
  input  logic                   available_write,
  input  logic                   write_ack,
  input  logic [`ACC_QID_W-1:0]  write_queue_id,
  input  logic [`ACC_DATA_W-1:0] elapsed,
  output logic                   freeze,
  output logic                   request_write,
  output logic [`ACC_ADDR_W-1:0] write_addr,
  output logic [`ACC_DATA_W-1:0] write_data,
  output logic                   done
);

  localparam logic [2:0] ST_IDLE     = 3'd0;
  localparam logic [2:0] ST_RUN      = 3'd1;
  localparam logic [2:0] ST_SEND     = 3'd2;
  localparam logic [2:0] ST_WAIT_ACK = 3'd3;
  localparam logic [2:0] ST_FINISHED = 3'd4;

  logic [2:0] state;

  assign request_write = (state == ST_SEND) && available_write;
  // Timer stops on the same edge that takes the status word
  assign freeze        = request_write;
  assign write_data    = elapsed;
  assign done          = (state == ST_FINISHED);

  always_ff @(posedge clk) begin
    if (conf_valid == conf_status) begin
      write_addr <= conf.s.addr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_RUN;
          end
        end
        ST_RUN: begin
          if ((&queue_done) && !kernel_busy) begin
            state <= ST_SEND;
          end
        end
        ST_SEND: begin
          if (request_write) begin
            state <= ST_WAIT_ACK;
          end
        end
        ST_WAIT_ACK: begin
          if (write_ack && (write_queue_id == QUEUE_ID)) begin
            state <= ST_FINISHED;
          end
        end
        default: begin
          state <= ST_FINISHED;
        end
      endcase
    end
  end

endmodule

// ==== rtl/acc_top.sv ====
`include "acc_cfg.svh"

module acc_top
  import acc_pkg::*;
(
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   start,
  input  conf_kind_t                             conf_valid,
  input  conf_word_u                             conf,
  input  logic [`ACC_NUM_IN-1:0]                 available_read,
  output logic [`ACC_NUM_IN-1:0]                 request_read,
  output logic [`ACC_NUM_IN-1:0][`ACC_ADDR_W-1:0] request_addr,
  input  logic                                   read_data_valid,
  input  logic [`ACC_QID_W-1:0]                  read_queue_id,
  input  logic [`ACC_DATA_W-1:0]                 read_data,
  input  logic [1:0]                             available_write,
  output logic [1:0]                             request_write,
  output logic [1:0][`ACC_ADDR_W-1:0]            write_addr,
  output logic [1:0][`ACC_DATA_W-1:0]            write_data,
  input  logic                                   write_ack,
  input  logic [`ACC_QID_W-1:0]                  write_queue_id,
  output logic                                   done
);

  localparam logic [`ACC_QID_W-1:0] OUT_QID    = `ACC_NUM_IN;
  localparam logic [`ACC_QID_W-1:0] STATUS_QID = `ACC_NUM_IN + 1;

  logic                                    start_reg;
  conf_kind_t                              conf_valid_reg;
  conf_word_u                              conf_reg;
  logic                                    read_data_valid_reg;
  logic [`ACC_QID_W-1:0]                   read_queue_id_reg;
  logic [`ACC_DATA_W-1:0]                  read_data_reg;
  logic                                    write_ack_reg;
  logic [`ACC_QID_W-1:0]                   write_queue_id_reg;
  logic [`ACC_NUM_IN-1:0]                  word_ready;
  logic [`ACC_NUM_IN-1:0][`ACC_DATA_W-1:0] word_data;
  logic [`ACC_NUM_IN-1:0]                  in_done;
  logic                                    out_done;
  logic                                    take;
  logic                                    push;
  logic [`ACC_DATA_W-1:0]                  push_data;
  logic                                    slot_free;
  logic                                    kernel_busy;
  logic                                    freeze;
  logic [`ACC_DATA_W-1:0]                  elapsed;

  // Host strobes and their data, one register stage
  always_ff @(posedge clk) begin
    if (rst) begin
      start_reg           <= 1'b0;
      conf_valid_reg      <= conf_none;
      read_data_valid_reg <= 1'b0;
      write_ack_reg       <= 1'b0;
    end else begin
      start_reg           <= start;
      conf_valid_reg      <= conf_valid;
      read_data_valid_reg <= read_data_valid;
      write_ack_reg       <= write_ack;
    end
  end

  always_ff @(posedge clk) begin
    conf_reg           <= conf;
    read_queue_id_reg  <= read_queue_id;
    read_data_reg      <= read_data;
    write_queue_id_reg <= write_queue_id;
  end

  for (genvar i = 0; i < `ACC_NUM_IN; i++) begin : gen_in_queue
    input_queue_ctrl #(
      .QUEUE_ID(`ACC_QID_W'(i))
    ) in_queue_i (
      .clk            (clk),
      .rst            (rst),
      .start          (start_reg),
      .conf_valid     (conf_valid_reg),
      .conf           (conf_reg),
      .available_read (available_read[i]),
      .read_data_valid(read_data_valid_reg),
      .read_queue_id  (read_queue_id_reg),
      .read_data      (read_data_reg),
      .take           (take),
      .request_read   (request_read[i]),
      .request_addr   (request_addr[i]),
      .word_ready     (word_ready[i]),
      .word_data      (word_data[i]),
      .done           (in_done[i])
    );
  end

  pair_sum_kernel kernel_i (
    .clk        (clk),
    .rst        (rst),
    .start      (start_reg),
    .word_ready (word_ready),
    .word_data  (word_data),
    .slot_free  (slot_free),
    .take       (take),
    .push       (push),
    .push_data  (push_data),
    .kernel_busy(kernel_busy)
  );

  output_queue_ctrl #(
    .QUEUE_ID(OUT_QID)
  ) out_queue_i (
    .clk            (clk),
    .rst            (rst),
    .start          (start_reg),
    .conf_valid     (conf_valid_reg),
    .conf           (conf_reg),
    .push           (push),
    .push_data      (push_data),
    .available_write(available_write[0]),
    .write_ack      (write_ack_reg),
    .write_queue_id (write_queue_id_reg),
    .slot_free      (slot_free),
    .request_write  (request_write[0]),
    .write_addr     (write_addr[0]),
    .write_data     (write_data[0]),
    .done           (out_done)
  );

  cycle_timer timer_i (
    .clk    (clk),
    .rst    (rst),
    .start  (start_reg),
    .freeze (freeze),
    .elapsed(elapsed)
  );

  status_ctrl #(
    .QUEUE_ID(STATUS_QID)
  ) status_i (
    .clk            (clk),
    .rst            (rst),
    .start          (start_reg),
    .conf_valid     (conf_valid_reg),
    .conf           (conf_reg),
    .queue_done     ({out_done, in_done}),
    .kernel_busy    (kernel_busy),
    .available_write(available_write[1]),
    .write_ack      (write_ack_reg),
    .write_queue_id (write_queue_id_reg),
    .elapsed        (elapsed),
    .freeze         (freeze),
    .request_write  (request_write[1]),
    .write_addr     (write_addr[1]),
    .write_data     (write_data[1]),
    .done           (done)
  );

endmodule

// ==== dv/acc_props.sv ====
`include "acc_cfg.svh"

module acc_props (
  input logic                   clk,
  input logic                   rst,
  input logic [`ACC_NUM_IN-1:0] available_read,
  input logic [`ACC_NUM_IN-1:0] request_read,
  input logic                   read_data_valid,
  input logic [`ACC_QID_W-1:0]  read_queue_id,
  input logic [1:0]             available_write,
  input logic [1:0]             request_write,
  input logic                   write_ack,
  input logic [`ACC_QID_W-1:0]  write_queue_id,
  input logic                   done
);

  logic [`ACC_NUM_IN-1:0] rd_out;
  logic [1:0]             wr_out;
  int                     fail_count = 0;

  // Request in flight per queue, cleared by the host answer
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_out <= '0;
      wr_out <= '0;
    end else begin
      for (int i = 0; i < `ACC_NUM_IN; i++) begin
        if (request_read[i]) begin
          rd_out[i] <= 1'b1;
        end else if (read_data_valid && read_queue_id == `ACC_QID_W'(i)) begin
          rd_out[i] <= 1'b0;
        end
      end
      for (int c = 0; c < 2; c++) begin
        if (request_write[c]) begin
          wr_out[c] <= 1'b1;
        end else if (write_ack && write_queue_id == `ACC_QID_W'(`ACC_NUM_IN + c)) begin
          wr_out[c] <= 1'b0;
        end
      end
    end
  end

  read_avail: assert property (@(posedge clk) disable iff (rst)
    (request_read & ~available_read) == '0)
    else begin
      $error("read request while available_read is low");
      fail_count++;
    end

  write_avail: assert property (@(posedge clk) disable iff (rst)
    (request_write & ~available_write) == '0)
    else begin
      $error("write request while available_write is low");
      fail_count++;
    end

  done_held: assert property (@(posedge clk) disable iff (rst) done |=> done)
    else begin
      $error("done fell without reset");
      fail_count++;
    end

  one_in_flight: assert property (@(posedge clk) disable iff (rst)
    ((request_read & rd_out) == '0) && ((request_write & wr_out) == '0))
    else begin
      $error("second request while one is outstanding");
      fail_count++;
    end

endmodule

bind acc_top acc_props props_i (.*);

// ==== dv/acc_tb.sv ====
`include "acc_cfg.svh"

module acc_tb
  import acc_pkg::*;
();

  localparam int DONE_TIMEOUT = 4000;
  localparam logic [`ACC_QID_W-1:0] STATUS_QID = `ACC_NUM_IN + 1;

  logic                                    clk;
  logic                                    rst;
  logic                                    start;
  conf_kind_t                              conf_valid;
  conf_word_u                              conf;
  logic [`ACC_NUM_IN-1:0]                  available_read;
  logic [`ACC_NUM_IN-1:0]                  request_read;
  logic [`ACC_NUM_IN-1:0][`ACC_ADDR_W-1:0] request_addr;
  logic                                    read_data_valid;
  logic [`ACC_QID_W-1:0]                   read_queue_id;
  logic [`ACC_DATA_W-1:0]                  read_data;
  logic [1:0]                              available_write;
  logic [1:0]                              request_write;
  logic [1:0][`ACC_ADDR_W-1:0]             write_addr;
  logic [1:0][`ACC_DATA_W-1:0]             write_data;
  logic                                    write_ack;
  logic [`ACC_QID_W-1:0]                   write_queue_id;
  logic                                    done;

  // Current run setup
  logic [`ACC_ADDR_W-1:0] in_base [`ACC_NUM_IN];
  logic [`ACC_ADDR_W-1:0] out_base;
  logic [`ACC_ADDR_W-1:0] status_addr;
  int                     word_count;
  int                     errors;
  bit                     aborted;

  // Host model state
  logic [31:0]            lfsr;
  int                     host_cycle;
  bit                     rd_pend [`ACC_NUM_IN];
  int                     rd_due [`ACC_NUM_IN];
  logic [`ACC_ADDR_W-1:0] rd_addr [`ACC_NUM_IN];
  bit                     wr_pend [2];
  int                     wr_due [2];

  // Monitor state
  int cycle;
  int start_edge;
  int rd_count [`ACC_NUM_IN];
  int wr_count;
  int status_writes;
  bit started_seen;
  bit status_acked;
  bit done_seen;

  acc_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task draw_bits(input int n, output logic [3:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[2:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Host memory contents
  function automatic logic [31:0] mem_word(input logic [`ACC_ADDR_W-1:0] addr);
    return {addr ^ 16'hc3a5, addr * 16'd40503};
  endfunction

  function automatic logic [31:0] expected_sum(input int k);
    return mem_word(in_base[0] + 16'(k)) + mem_word(in_base[1] + 16'(k));
  endfunction

  task report_mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
    $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
    errors++;
  endtask

  task report_problem(input string what);
    $display("%s at time %0t", what, $time);
    errors++;
  endtask

  // Host model with random availability, delayed read data and delayed write acks
  always @(posedge clk) begin
    logic [3:0] r;
    bit         sent;
    host_cycle = host_cycle + 1;
    read_data_valid <= 1'b0;
    write_ack       <= 1'b0;
    for (int q = 0; q < `ACC_NUM_IN; q++) begin
      draw_bits(1, r);
      available_read[q] <= r[0];
    end
    for (int c = 0; c < 2; c++) begin
      draw_bits(1, r);
      available_write[c] <= r[0];
    end
    if (rst) begin
      rd_pend = '{default: 1'b0};
      wr_pend = '{default: 1'b0};
    end else begin
      sent = 1'b0;
      for (int q = 0; q < `ACC_NUM_IN; q++) begin
        if (rd_pend[q] && !sent && rd_due[q] <= host_cycle) begin
          read_data_valid <= 1'b1;
          read_queue_id   <= `ACC_QID_W'(q);
          read_data       <= mem_word(rd_addr[q]);
          rd_pend[q] = 1'b0;
          sent       = 1'b1;
        end
      end
      sent = 1'b0;
      for (int c = 0; c < 2; c++) begin
        if (wr_pend[c] && !sent && wr_due[c] <= host_cycle) begin
          write_ack      <= 1'b1;
          write_queue_id <= `ACC_QID_W'(`ACC_NUM_IN + c);
          wr_pend[c] = 1'b0;
          sent       = 1'b1;
        end
      end
      for (int q = 0; q < `ACC_NUM_IN; q++) begin
        if (request_read[q]) begin
          draw_bits(2, r);
          rd_pend[q] = 1'b1;
          rd_due[q]  = host_cycle + 1 + r;
          rd_addr[q] = request_addr[q];
        end
      end
      for (int c = 0; c < 2; c++) begin
        if (request_write[c]) begin
          draw_bits(2, r);
          wr_pend[c] = 1'b1;
          wr_due[c]  = host_cycle + 1 + r;
        end
      end
    end
  end

  // Compare every request and write against the run setup
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (rst) begin
      rd_count      = '{default: 0};
      wr_count      = 0;
      status_writes = 0;
      started_seen  = 1'b0;
      status_acked  = 1'b0;
      done_seen     = 1'b0;
    end else begin
      if (start) begin
        started_seen = 1'b1;
        start_edge   = cycle;
      end
      if ((|request_write) && !started_seen) begin
        report_problem("Write request seen before start");
      end
      for (int q = 0; q < `ACC_NUM_IN; q++) begin
        if (request_read[q]) begin
          if (request_addr[q] !== in_base[q] + 16'(rd_count[q])) begin
            report_mismatch($sformatf("read address of queue %0d", q), 32'(request_addr[q]),
                            32'(in_base[q] + 16'(rd_count[q])));
          end
          rd_count[q]++;
        end
      end
      if (request_write[0]) begin
        if (wr_count >= word_count) begin
          report_problem("More output writes than configured");
        end else begin
          if (write_addr[0] !== out_base + 16'(wr_count)) begin
            report_mismatch("output write address", 32'(write_addr[0]),
                            32'(out_base + 16'(wr_count)));
          end
          if (write_data[0] !== expected_sum(wr_count)) begin
            report_mismatch($sformatf("output word %0d", wr_count), write_data[0],
                            expected_sum(wr_count));
          end
        end
        wr_count++;
      end
      if (request_write[1]) begin
        status_writes++;
        if (write_addr[1] !== status_addr) begin
          report_mismatch("status address", 32'(write_addr[1]), 32'(status_addr));
        end
        if (write_data[1] !== 32'(cycle - start_edge - 1)) begin
          report_mismatch("status cycle count", write_data[1], 32'(cycle - start_edge - 1));
        end
      end
      if (write_ack && write_queue_id == STATUS_QID) begin
        status_acked = 1'b1;
      end
      if (done && !status_acked) begin
        report_problem("Done rose before the status write was acknowledged");
      end
      if (done_seen && !done) begin
        report_problem("Done dropped before reset");
      end
      if (done) begin
        done_seen = 1'b1;
      end
    end
  end

  task reset_dut;
    @(posedge clk);
    rst <= 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
  endtask

  task send_conf(input conf_kind_t kind, input conf_word_u w);
    @(posedge clk);
    conf_valid <= kind;
    conf       <= w;
    @(posedge clk);
    conf_valid <= conf_none;
    conf       <= '0;
  endtask

  task send_queue_conf(input logic [`ACC_QID_W-1:0] qid, input logic [`ACC_ADDR_W-1:0] base,
                       input int count);
    conf_word_u w;
    w.q.qid   = qid;
    w.q.base  = base;
    w.q.count = `ACC_CNT_W'(count);
    send_conf(conf_queue, w);
  endtask

  task send_status_conf(input logic [`ACC_ADDR_W-1:0] addr);
    conf_word_u w;
    w        = '0;
    w.s.addr = addr;
    send_conf(conf_status, w);
  endtask

  task wait_done(output bit timed_out);
    int n;
    n = 0;
    while (!done && n < DONE_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    timed_out = !done;
  endtask

  task run_test(input int run, input int count, input logic [`ACC_ADDR_W-1:0] b0,
                input logic [`ACC_ADDR_W-1:0] b1, input logic [`ACC_ADDR_W-1:0] ob,
                input logic [`ACC_ADDR_W-1:0] sa, input bit status_first);
    bit timed_out;
    word_count  = count;
    in_base[0]  = b0;
    in_base[1]  = b1;
    out_base    = ob;
    status_addr = sa;
    reset_dut();
    if (status_first) begin
      send_status_conf(sa);
    end
    send_queue_conf(`ACC_QID_W'(0), b0, count);
    send_queue_conf(`ACC_QID_W'(1), b1, count);
    send_queue_conf(`ACC_QID_W'(`ACC_NUM_IN), ob, count);
    if (!status_first) begin
      send_status_conf(sa);
    end
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    wait_done(timed_out);
    if (timed_out) begin
      report_problem($sformatf("Timed out waiting for done in run %0d", run));
      aborted = 1'b1;
      return;
    end
    // Let the DUT idle to catch late strobes
    repeat (20) @(posedge clk);
    @(negedge clk);
    for (int q = 0; q < `ACC_NUM_IN; q++) begin
      if (rd_count[q] != count) begin
        report_mismatch($sformatf("read requests of queue %0d", q), rd_count[q], count);
      end
    end
    if (wr_count != count) begin
      report_mismatch("output write count", wr_count, count);
    end
    if (status_writes != 1) begin
      report_mismatch("status write count", status_writes, 1);
    end
    if (!done) begin
      report_problem("Done is low at the end of the run");
    end
  endtask

  initial begin
    rst             = 1'b1;
    start           = 1'b0;
    conf_valid      = conf_none;
    conf            = '0;
    available_read  = '0;
    read_data_valid = 1'b0;
    read_queue_id   = '0;
    read_data       = '0;
    available_write = '0;
    write_ack       = 1'b0;
    write_queue_id  = '0;
    lfsr            = 32'h4efb_28c9;
    errors          = 0;
    aborted         = 1'b0;
    run_test(0, 12, 16'h0100, 16'h0840, 16'h2000, 16'h3ff0, 1'b0);
    if (!aborted) begin
      run_test(1, 7, 16'h5123, 16'h0a07, 16'h6e00, 16'h7abc, 1'b1);
    end
    $display("Run finished with %0d check errors and %0d assertion failures", errors,
             dut_i.props_i.fail_count);
    if (errors == 0 && dut_i.props_i.fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/acc_pkg.sv
rtl/input_queue_ctrl.sv
rtl/output_queue_ctrl.sv
rtl/pair_sum_kernel.sv
rtl/cycle_timer.sv
rtl/status_ctrl.sv
rtl/acc_top.sv
dv/acc_props.sv
dv/acc_tb.sv

// ==== Bender.yml ====
package:
  name: acc_stream

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/acc_pkg.sv
      - rtl/input_queue_ctrl.sv
      - rtl/output_queue_ctrl.sv
      - rtl/pair_sum_kernel.sv
      - rtl/cycle_timer.sv
      - rtl/status_ctrl.sv
      - rtl/acc_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/acc_props.sv
      - dv/acc_tb.sv
